// ==== hdl/board_consts.svh ====
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

// apb address space
`define APB_AW 8

`define REG_LED     8'h00
`define REG_SEG     8'h04
`define REG_SEG_EN  8'h08
`define REG_ALU     8'h0C
`define REG_ALU_ST  8'h10 // read only
`define REG_FB_ADDR 8'h14
`define REG_FB_DATA 8'h18

// 640x480 at one pixel per clock
`define H_VISIBLE 640
`define H_FRONT   16
`define H_SYNC    96
`define H_BACK    48

`define V_VISIBLE 480
`define V_FRONT   10
`define V_SYNC    2
`define V_BACK    33

// 16x16 pixel tiles
`define TILE_SHIFT 4
`define FB_COLS    40
`define FB_ROWS    30

`endif

// ==== hdl/board_pkg.sv ====
`default_nettype none
`include "board_consts.svh"

package board_pkg;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [`APB_AW-1:0] paddr;
        logic [31:0]       pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    // function codes as written to REG_ALU bits 10:8
    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_not_a  = 3'd2,
        alu_and_ab = 3'd3,
        alu_or_ab  = 3'd4,
        alu_xor_ab = 3'd5,
        alu_lt     = 3'd6, // signed
        alu_eq     = 3'd7
    } alu_op_e;

    typedef struct packed {
        logic zero;
        logic overflow;
        logic carry;
    } alu_flags_t;

endpackage

`default_nettype wire

// ==== hdl/video_pkg.sv ====
`default_nettype none

package video_pkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // syncs are active low
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic valid;
    } vga_sync_t;

    // one byte per digit, active low, bit 7 is the decimal point
    typedef logic [7:0][7:0] seg_bank_t;

endpackage

`default_nettype wire

// ==== hdl/apb_regs.sv ====
`default_nettype none
`include "board_consts.svh"

module apb_regs (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire board_pkg::apb_req_t   apb_req,
    output board_pkg::apb_rsp_t        apb_rsp,
    output logic [15:0]                led_q,
    output logic [31:0]                digit_val,
    output logic [7:0]                 digit_en,
    output logic [3:0]                 alu_a,
    output logic [3:0]                 alu_b,
    output board_pkg::alu_op_e         alu_op,
    input  wire logic [3:0]            alu_res,
    input  wire board_pkg::alu_flags_t alu_flags,
    output logic                       fb_we,
    output logic [10:0]                fb_waddr,
    output logic [11:0]                fb_wdata
);
    import board_pkg::*;

    localparam logic [10:0] FB_LAST = 11'(`FB_COLS * `FB_ROWS - 1);

    logic        access;
    logic        wr;
    logic        hit;
    logic [31:0] rdata;
    logic [10:0] fb_addr;

    assign access = apb_req.psel & apb_req.penable;
    assign wr     = access & apb_req.pwrite & hit; // unmapped writes dropped

    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (apb_req.paddr)
            `REG_LED:     rdata = {16'h0, led_q};
            `REG_SEG:     rdata = digit_val;
            `REG_SEG_EN:  rdata = {24'h0, digit_en};
            `REG_ALU:     rdata = {21'h0, alu_op, alu_b, alu_a};
            `REG_ALU_ST:  rdata = {25'h0, alu_flags.carry, alu_flags.overflow,
                                   alu_flags.zero, alu_res};
            `REG_FB_ADDR: rdata = {21'h0, fb_addr};
            `REG_FB_DATA: rdata = '0; // write only
            default:      hit = 1'b0;
        endcase
    end

    // zero wait states
    assign apb_rsp = '{pready: 1'b1, prdata: rdata, pslverr: access & ~hit};

    // store happens on the same edge as the address bump
    assign fb_we    = wr & (apb_req.paddr == `REG_FB_DATA);
    assign fb_waddr = fb_addr;
    assign fb_wdata = apb_req.pwdata[11:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_q     <= '0;
            digit_val <= '0;
            digit_en  <= '0;
            alu_a     <= '0;
            alu_b     <= '0;
            alu_op    <= alu_add;
            fb_addr   <= '0;
        end else if (wr) begin
            case (apb_req.paddr)
                `REG_LED:     led_q <= apb_req.pwdata[15:0];
                `REG_SEG:     digit_val <= apb_req.pwdata;
                `REG_SEG_EN:  digit_en <= apb_req.pwdata[7:0];
                `REG_ALU: begin
                    alu_a  <= apb_req.pwdata[3:0];
                    alu_b  <= apb_req.pwdata[7:4];
                    alu_op <= alu_op_e'(apb_req.pwdata[10:8]);
                end
                `REG_FB_ADDR: fb_addr <= apb_req.pwdata[10:0];
                `REG_FB_DATA: fb_addr <= (fb_addr == FB_LAST) ? '0 : fb_addr + 11'd1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/alu_4bit.sv ====
`default_nettype none

module alu_4bit (
    input  wire logic [3:0]        alu_a,
    input  wire logic [3:0]        alu_b,
    input  wire board_pkg::alu_op_e alu_op,
    output logic [3:0]             alu_res,
    output board_pkg::alu_flags_t  alu_flags
);
    import board_pkg::*;

    logic [4:0] sum_add;
    logic [4:0] sum_sub;

    assign sum_add = {1'b0, alu_a} + {1'b0, alu_b};
    assign sum_sub = {1'b0, alu_a} + {1'b0, ~alu_b} + 5'd1; // msb is not borrow

    always_comb begin
        alu_res   = '0;
        alu_flags = '0;
        case (alu_op)
            alu_add: begin
                alu_res            = sum_add[3:0];
                alu_flags.carry    = sum_add[4];
                alu_flags.overflow = (alu_a[3] == alu_b[3]) && (sum_add[3] != alu_a[3]);
            end
            alu_sub: begin
                alu_res            = sum_sub[3:0];
                alu_flags.carry    = sum_sub[4];
                alu_flags.overflow = (alu_a[3] != alu_b[3]) && (sum_sub[3] != alu_a[3]);
            end
            alu_not_a:  alu_res = ~alu_a;
            alu_and_ab: alu_res = alu_a & alu_b;
            alu_or_ab:  alu_res = alu_a | alu_b;
            alu_xor_ab: alu_res = alu_a ^ alu_b;
            alu_lt:     alu_res = {3'b000, $signed(alu_a) < $signed(alu_b)};
            alu_eq:     alu_res = {3'b000, alu_a == alu_b};
            default:    alu_res = '0;
        endcase
        alu_flags.zero = (alu_res == 4'h0);
    end

endmodule

`default_nettype wire

// ==== hdl/seg_digit.sv ====
`default_nettype none

module seg_digit (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic [3:0] nibble,
    input  wire logic       en,
    output logic [7:0]      seg_raw,
    output logic            is_zero
);

    logic [7:0] hex_pat;

    // active low, bit 0 is segment a, dp kept off
    always_comb begin
        case (nibble)
            4'h0: hex_pat = 8'hC0;
            4'h1: hex_pat = 8'hF9;
            4'h2: hex_pat = 8'hA4;
            4'h3: hex_pat = 8'hB0;
            4'h4: hex_pat = 8'h99;
            4'h5: hex_pat = 8'h92;
            4'h6: hex_pat = 8'h82;
            4'h7: hex_pat = 8'hF8;
            4'h8: hex_pat = 8'h80;
            4'h9: hex_pat = 8'h90;
            4'hA: hex_pat = 8'h88;
            4'hB: hex_pat = 8'h83;
            4'hC: hex_pat = 8'hC6;
            4'hD: hex_pat = 8'hA1;
            4'hE: hex_pat = 8'h86;
            default: hex_pat = 8'h8E;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg_raw <= 8'hFF;
            is_zero <= 1'b0;
        end else begin
            seg_raw <= en ? hex_pat : 8'hFF; // dark when disabled
            is_zero <= en && (nibble == 4'h0);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/seg_blank.sv ====
`default_nettype none

module seg_blank (
    input  wire logic [7:0][7:0] seg_raw,
    input  wire logic [7:0]      is_zero,
    output video_pkg::seg_bank_t seg
);

    logic leading;

    always_comb begin
        leading = 1'b1;
        for (int i = 7; i >= 1; i--) begin
            if (leading && is_zero[i]) begin
                seg[i] = 8'hFF;
            end else begin
                seg[i] = seg_raw[i];
            end
            // a disabled digit reads back all ones and does not end the run
            if (!is_zero[i] && seg_raw[i] != 8'hFF) begin
                leading = 1'b0;
            end
        end
        seg[0] = seg_raw[0]; // units digit always visible
    end

endmodule

`default_nettype wire

// ==== hdl/vga_ctrl.sv ====
`default_nettype none
`include "board_consts.svh"

module vga_ctrl (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire video_pkg::rgb_t pixel,
    output logic [9:0]           h_addr,
    output logic [9:0]           v_addr,
    output video_pkg::vga_sync_t vga_sync,
    output video_pkg::rgb_t      vga_rgb
);
    import video_pkg::*;

    localparam int H_TOTAL = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int H_SYNC_START = `H_VISIBLE + `H_FRONT;
    localparam int V_SYNC_START = `V_VISIBLE + `V_FRONT;

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    vga_sync_t  sync_now;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == 10'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == 10'(V_TOTAL - 1)) ? '0 : v_cnt + 10'd1;
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    always_comb begin
        sync_now.hsync = !(h_cnt >= H_SYNC_START && h_cnt < H_SYNC_START + `H_SYNC);
        sync_now.vsync = !(v_cnt >= V_SYNC_START && v_cnt < V_SYNC_START + `V_SYNC);
        sync_now.valid = (h_cnt < `H_VISIBLE) && (v_cnt < `V_VISIBLE);
    end

    assign h_addr = h_cnt;
    assign v_addr = v_cnt;

    // one stage to line up with the vmem read register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vga_sync <= '{hsync: 1'b1, vsync: 1'b1, valid: 1'b0};
        end else begin
            vga_sync <= sync_now;
        end
    end

    assign vga_rgb = vga_sync.valid ? pixel : '0; // black in blanking

endmodule

`default_nettype wire

// ==== hdl/vmem.sv ====
`default_nettype none
`include "board_consts.svh"

module vmem (
    input  wire logic        clk,
    input  wire logic        we,
    input  wire logic [10:0] waddr,
    input  wire logic [11:0] wdata,
    input  wire logic [9:0]  h_addr,
    input  wire logic [9:0]  v_addr,
    output video_pkg::rgb_t  pixel
);

    localparam int FB_SIZE = `FB_COLS * `FB_ROWS;

    logic [11:0] mem [FB_SIZE];
    logic [10:0] tile_idx;
    logic [11:0] rd_q;

    assign tile_idx = 11'(v_addr >> `TILE_SHIFT) * 11'(`FB_COLS) + 11'(h_addr >> `TILE_SHIFT);

    always_ff @(posedge clk) begin
        if (we && waddr < FB_SIZE) begin
            mem[waddr] <= wdata;
        end
        rd_q <= (tile_idx < FB_SIZE) ? mem[tile_idx] : 12'h000; // blanking area reads zero
    end

    // 4 bit channels widened by repeating the nibble
    assign pixel = '{r: {2{rd_q[11:8]}}, g: {2{rd_q[7:4]}}, b: {2{rd_q[3:0]}}};

endmodule

`default_nettype wire

// ==== hdl/board_top.sv ====
`default_nettype none

module board_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire board_pkg::apb_req_t   apb_req,
    output board_pkg::apb_rsp_t        apb_rsp,
    output logic [15:0]                ledr,
    output video_pkg::seg_bank_t       seg,
    output video_pkg::vga_sync_t       vga_sync,
    output video_pkg::rgb_t            vga_rgb,
    output board_pkg::alu_flags_t      alu_flags
);
    import board_pkg::*;
    import video_pkg::*;

    logic [31:0]      digit_val;
    logic [7:0]       digit_en;
    logic [3:0]       alu_a;
    logic [3:0]       alu_b;
    alu_op_e          alu_op;
    logic [3:0]       alu_res;
    logic             fb_we;
    logic [10:0]      fb_waddr;
    logic [11:0]      fb_wdata;
    logic [7:0][7:0]  seg_raw;
    logic [7:0]       digit_zero;
    logic [9:0]       h_addr;
    logic [9:0]       v_addr;
    rgb_t             pixel;

    apb_regs i_apb_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .led_q     (ledr),
        .digit_val (digit_val),
        .digit_en  (digit_en),
        .alu_a     (alu_a),
        .alu_b     (alu_b),
        .alu_op    (alu_op),
        .alu_res   (alu_res),
        .alu_flags (alu_flags),
        .fb_we     (fb_we),
        .fb_waddr  (fb_waddr),
        .fb_wdata  (fb_wdata)
    );

    alu_4bit i_alu (
        .alu_a     (alu_a),
        .alu_b     (alu_b),
        .alu_op    (alu_op),
        .alu_res   (alu_res),
        .alu_flags (alu_flags) // also mirrored to the board
    );

    for (genvar i = 0; i < 8; i++) begin : g_digit
        seg_digit i_seg_digit (
            .clk     (clk),
            .rst_n   (rst_n),
            .nibble  (digit_val[4*i +: 4]),
            .en      (digit_en[i]),
            .seg_raw (seg_raw[i]),
            .is_zero (digit_zero[i])
        );
    end

    seg_blank i_seg_blank (
        .seg_raw (seg_raw),
        .is_zero (digit_zero),
        .seg     (seg)
    );

    vga_ctrl i_vga_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .pixel    (pixel),
        .h_addr   (h_addr),
        .v_addr   (v_addr),
        .vga_sync (vga_sync),
        .vga_rgb  (vga_rgb)
    );

    vmem i_vmem (
        .clk    (clk),
        .we     (fb_we),
        .waddr  (fb_waddr),
        .wdata  (fb_wdata),
        .h_addr (h_addr),
        .v_addr (v_addr),
        .pixel  (pixel)
    );

endmodule

`default_nettype wire

// ==== sim/board_tb.sv ====
`default_nettype none
`include "board_consts.svh"

module board_tb;
    import board_pkg::*;
    import video_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int H_TOTAL = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;
    localparam int FB_SIZE = `FB_COLS * `FB_ROWS;
    localparam int REG_REPS = 16;
    localparam int ALU_REPS = 200;
    localparam int SEG_REPS = 32;
    // transfers over all tests, two clocks each
    localparam int APB_XFERS = REG_REPS * 10 + ALU_REPS * 2 + (SEG_REPS + 5) * 2 + FB_SIZE + 140;
    localparam int WATCHDOG_CLKS = 3 * FRAME_CLKS + 2 * APB_XFERS + 20000;

    // active low, bit 0 is segment a
    localparam logic [15:0][7:0] HEX_SEGS = {
        8'h8E, 8'h86, 8'hA1, 8'hC6, 8'h83, 8'h88, 8'h90, 8'h80,
        8'hF8, 8'h82, 8'h92, 8'h99, 8'hB0, 8'hA4, 8'hF9, 8'hC0
    };

    logic        clk = 1'b0;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [15:0] ledr;
    seg_bank_t   seg;
    vga_sync_t   vga_sync;
    rgb_t        vga_rgb;
    alu_flags_t  alu_flags;

    logic [31:0] rng_state = 32'd56279;
    logic [11:0] shadow_fb [FB_SIZE];
    logic [7:0]  en_shadow = 8'h00;
    int          fb_ptr = 0;
    logic        video_on = 1'b0;
    int          error_count = 0;
    int          scan_h = 0;
    int          scan_v = 0;

    board_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .ledr      (ledr),
        .seg       (seg),
        .vga_sync  (vga_sync),
        .vga_rgb   (vga_rgb),
        .alu_flags (alu_flags)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_CLKS * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CLKS);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    task automatic report_error(input string msg);
        error_count++;
        $display("Error at time %0t: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [31:0] lcg_next();
        logic [31:0] hi;
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        hi = {rng_state[31:16], 16'h0000};
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return hi | {16'h0000, rng_state[31:16]}; // upper halves only
    endfunction

    function automatic logic [6:0] ref_alu(input logic [3:0] a, input logic [3:0] b,
                                           input logic [2:0] op);
        int   sa;
        int   sb;
        int   r;
        logic c;
        logic v;
        sa = a[3] ? int'(a) - 16 : int'(a);
        sb = b[3] ? int'(b) - 16 : int'(b);
        c = 1'b0;
        v = 1'b0;
        case (op)
            3'd0: begin
                r = int'(a) + int'(b);
                c = r > 15;
                v = (sa + sb > 7) || (sa + sb < -8);
            end
            3'd1: begin
                r = int'(a) - int'(b);
                c = a >= b; // no borrow
                v = (sa - sb > 7) || (sa - sb < -8);
            end
            3'd2: r = 15 - int'(a);
            3'd3: r = int'(a & b);
            3'd4: r = int'(a | b);
            3'd5: r = int'(a ^ b);
            3'd6: r = (sa < sb) ? 1 : 0;
            default: r = (a == b) ? 1 : 0;
        endcase
        return {c, v, r[3:0] == 4'h0, r[3:0]};
    endfunction

    function automatic seg_bank_t ref_seg(input logic [31:0] val, input logic [7:0] en);
        seg_bank_t s;
        logic      leading;
        leading = 1'b1;
        for (int i = 7; i >= 0; i--) begin
            if (!en[i]) begin
                s[i] = 8'hFF;
            end else if (i > 0 && leading && val[4*i +: 4] == 4'h0) begin
                s[i] = 8'hFF; // leading zero
            end else begin
                s[i] = HEX_SEGS[val[4*i +: 4]];
                leading = 1'b0;
            end
        end
        return s;
    endfunction

    function automatic vga_sync_t ref_sync(input int h, input int v);
        vga_sync_t s;
        s.hsync = !(h >= `H_VISIBLE + `H_FRONT && h < `H_VISIBLE + `H_FRONT + `H_SYNC);
        s.vsync = !(v >= `V_VISIBLE + `V_FRONT && v < `V_VISIBLE + `V_FRONT + `V_SYNC);
        s.valid = (h < `H_VISIBLE) && (v < `V_VISIBLE);
        return s;
    endfunction

    function automatic rgb_t ref_pixel(input int h, input int v);
        logic [11:0] c;
        c = shadow_fb[(v >> `TILE_SHIFT) * `FB_COLS + (h >> `TILE_SHIFT)];
        return '{r: {2{c[11:8]}}, g: {2{c[7:4]}}, b: {2{c[3:0]}}};
    endfunction

    // outputs after an edge belong to the counters before it
    always @(posedge clk) begin : video_compare
        int        h;
        int        v;
        vga_sync_t exp_sync;
        rgb_t      exp_rgb;
        if (!rst_n) begin
            scan_h = 0;
            scan_v = 0;
        end else begin
            h = scan_h;
            v = scan_v;
            scan_h = (h == H_TOTAL - 1) ? 0 : h + 1;
            if (h == H_TOTAL - 1) begin
                scan_v = (v == V_TOTAL - 1) ? 0 : v + 1;
            end
            #2;
            if (video_on) begin
                exp_sync = ref_sync(h, v);
                exp_rgb = exp_sync.valid ? ref_pixel(h, v) : '0;
                assert (vga_sync == exp_sync && vga_rgb == exp_rgb)
                else report_error($sformatf("pixel (%0d,%0d): sync %b rgb %h, expected %b %h",
                                  h, v, vga_sync, vga_rgb, exp_sync, exp_rgb));
            end
        end
    end

    // called one unit after an edge; returns one unit after the edge that ends the access
    task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        #1;
        assert (apb_rsp.pready) else report_error("pready low in the access cycle");
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req.psel = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        assert (err == exp_err)
        else report_error($sformatf("write 0x%02h: pslverr %0b, expected %0b", addr, err, exp_err));
        if (addr == `REG_SEG_EN) begin
            en_shadow = data[7:0];
        end
        if (addr == `REG_FB_ADDR) begin
            fb_ptr = int'(data[10:0]);
        end
        if (addr == `REG_FB_DATA) begin
            shadow_fb[fb_ptr] = data[11:0];
            fb_ptr++;
        end
    endtask

    task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp_data,
                               input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, rd, err);
        assert (err == exp_err && (exp_err || rd == exp_data))
        else report_error($sformatf("read 0x%02h: data %h err %0b, expected %h err %0b",
                          addr, rd, err, exp_data, exp_err));
    endtask

    task automatic registers_readback();
        logic [31:0] led_v;
        logic [31:0] seg_v;
        logic [31:0] en_v;
        logic [31:0] alu_v;
        for (int i = 0; i < REG_REPS; i++) begin
            led_v = lcg_next();
            seg_v = lcg_next();
            en_v = lcg_next();
            alu_v = lcg_next();
            apb_write(`REG_LED, led_v, 1'b0);
            assert (ledr == led_v[15:0])
            else report_error($sformatf("ledr %h, expected %h", ledr, led_v[15:0]));
            apb_write(`REG_SEG, seg_v, 1'b0);
            apb_write(`REG_SEG_EN, en_v, 1'b0);
            apb_write(`REG_ALU, alu_v, 1'b0);
            read_expect(`REG_LED, {16'h0, led_v[15:0]}, 1'b0);
            read_expect(`REG_SEG, seg_v, 1'b0);
            read_expect(`REG_SEG_EN, {24'h0, en_v[7:0]}, 1'b0);
            read_expect(`REG_ALU, {21'h0, alu_v[10:0]}, 1'b0);
            apb_write(8'h1C + 8'(4 * i), lcg_next(), 1'b1);
            read_expect(8'h80 | 8'(i), 32'h0, 1'b1);
            assert (ledr == led_v[15:0])
            else report_error($sformatf("ledr %h after unmapped write, expected %h",
                              ledr, led_v[15:0]));
        end
    endtask

    task automatic alu_sweep();
        logic [31:0] r;
        logic [3:0]  a;
        logic [3:0]  b;
        logic [2:0]  op;
        logic [6:0]  exp;
        for (int i = 0; i < ALU_REPS; i++) begin
            r = lcg_next();
            a = r[3:0];
            b = r[7:4];
            op = (i < 8) ? 3'(i) : r[10:8]; // every op at least once
            apb_write(`REG_ALU, {21'h0, op, b, a}, 1'b0);
            exp = ref_alu(a, b, op);
            read_expect(`REG_ALU_ST, {25'h0, exp}, 1'b0);
            assert (alu_flags == {exp[4], exp[5], exp[6]})
            else report_error($sformatf("alu_flags %b for a=%h b=%h op=%0d", alu_flags, a, b, op));
        end
    endtask

    task automatic show_digits(input logic [31:0] val, input logic [7:0] en);
        logic [7:0] old_en;
        old_en = en_shadow;
        apb_write(`REG_SEG, val, 1'b0);
        apb_write(`REG_SEG_EN, {24'h0, en}, 1'b0);
        assert (seg == ref_seg(val, old_en)) // new mask not yet visible
        else report_error($sformatf("seg %h changed early for %h/%h", seg, val, en));
        @(posedge clk);
        #1;
        assert (seg == ref_seg(val, en))
        else report_error($sformatf("seg %h, expected %h for %h/%h",
                          seg, ref_seg(val, en), val, en));
    endtask

    task automatic segment_display();
        logic [31:0] val;
        logic [31:0] r;
        show_digits(32'h0000_0000, 8'hFF);
        show_digits(32'h9000_0000, 8'hFF);
        show_digits(32'h0000_5000, 8'hFF);
        show_digits(32'h0005_0000, 8'hDF); // gap above the lit digit
        show_digits(32'h0000_0100, 8'hFB); // gap inside the zero run
        for (int i = 0; i < SEG_REPS; i++) begin
            val = lcg_next();
            r = lcg_next();
            for (int j = 0; j < 8; j++) begin
                if (r[8 + j]) begin
                    val[4*j +: 4] = 4'h0;
                end
            end
            show_digits(val, r[7:0]);
        end
    endtask

    task automatic measure_sync_timing();
        vga_sync_t prev;
        vga_sync_t cur;
        int        h_period;
        int        h_low;
        int        v_low;
        int        valid_len;
        int        lines;
        int        valid_lines;
        int        vsync_pulses;
        logic      seen_hfall;
        logic      seen_vrise;
        prev = '0;
        cur = vga_sync;
        while (!(prev.vsync && !cur.vsync)) begin
            prev = cur;
            @(posedge clk);
            #1;
            cur = vga_sync;
        end
        h_period = 0;
        h_low = 0;
        v_low = 1;
        valid_len = 0;
        lines = 0;
        valid_lines = 0;
        vsync_pulses = 0;
        seen_hfall = 1'b0;
        seen_vrise = 1'b0;
        for (int n = 1; n < FRAME_CLKS; n++) begin
            prev = cur;
            @(posedge clk);
            #1;
            cur = vga_sync;
            h_period++;
            if (prev.hsync && !cur.hsync) begin
                assert (!seen_hfall || h_period == H_TOTAL)
                else report_error($sformatf("hsync period %0d clocks", h_period));
                seen_hfall = 1'b1;
                lines++;
                h_period = 0;
                h_low = 0;
            end
            if (!cur.hsync) begin
                h_low++;
            end
            if (!prev.hsync && cur.hsync && seen_hfall) begin
                assert (h_low == `H_SYNC) else report_error($sformatf("hsync low %0d", h_low));
            end
            if (!prev.valid && cur.valid) begin
                seen_vrise = 1'b1;
                valid_len = 0;
            end
            if (cur.valid) begin
                valid_len++;
            end
            if (prev.valid && !cur.valid && seen_vrise) begin
                assert (valid_len == `H_VISIBLE)
                else report_error($sformatf("valid high %0d clocks in a line", valid_len));
                valid_lines++;
            end
            if (!cur.vsync) begin
                v_low++;
            end
            if (!prev.vsync && cur.vsync) begin
                assert (v_low == `V_SYNC * H_TOTAL)
                else report_error($sformatf("vsync low %0d clocks", v_low));
                vsync_pulses++;
            end
        end
        assert (lines == V_TOTAL && valid_lines == `V_VISIBLE && vsync_pulses == 1)
        else report_error($sformatf("frame had %0d lines, %0d visible, %0d vsync pulses",
                          lines, valid_lines, vsync_pulses));
    endtask

    task automatic framebuffer_scan();
        logic [31:0] r;
        int          start;
        apb_write(`REG_FB_ADDR, 32'h0, 1'b0);
        for (int i = 0; i < FB_SIZE; i++) begin
            apb_write(`REG_FB_DATA, 32'(12'(i * 37 + 347)), 1'b0); // a different colour per tile
        end
        for (int i = 0; i < 56; i++) begin
            r = lcg_next();
            apb_write(`REG_FB_ADDR, 32'(r[31:16] % FB_SIZE), 1'b0);
            apb_write(`REG_FB_DATA, {20'h0, r[11:0]}, 1'b0);
        end
        r = lcg_next();
        start = int'(r[31:16] % (FB_SIZE - 8));
        apb_write(`REG_FB_ADDR, 32'(start), 1'b0);
        for (int i = 0; i < 8; i++) begin
            apb_write(`REG_FB_DATA, lcg_next(), 1'b0);
        end
        read_expect(`REG_FB_ADDR, 32'(start + 8), 1'b0);
        video_on = 1'b1;
        repeat (FRAME_CLKS + 2) @(posedge clk);
        #1;
        video_on = 1'b0;
    endtask

    initial begin
        apb_req = '0;
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        assert (ledr == 16'h0 && seg == '1 && vga_sync == 3'b110)
        else report_error($sformatf("in reset: ledr %h seg %h sync %b", ledr, seg, vga_sync));
        rst_n = 1'b1;
        registers_readback();
        alu_sweep();
        segment_display();
        measure_sync_timing();
        framebuffer_scan();
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== board_top.f ====
+incdir+hdl
hdl/board_pkg.sv
hdl/video_pkg.sv
hdl/apb_regs.sv
hdl/alu_4bit.sv
hdl/seg_digit.sv
hdl/seg_blank.sv
hdl/vga_ctrl.sv
hdl/vmem.sv
hdl/board_top.sv
sim/board_tb.sv

// ==== Bender.yml ====
package:
  name: board_top

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/board_pkg.sv
      - hdl/video_pkg.sv
      - hdl/apb_regs.sv
      - hdl/alu_4bit.sv
      - hdl/seg_digit.sv
      - hdl/seg_blank.sv
      - hdl/vga_ctrl.sv
      - hdl/vmem.sv
      - hdl/board_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/board_tb.sv
